// File: common/modarith_pkg.sv
package modarith_pkg;

	localparam int FIELD_WIDTH = 256;
	localparam int WORD_WIDTH  = 32;
	localparam int WORD_COUNT  = FIELD_WIDTH / WORD_WIDTH;

	typedef logic [FIELD_WIDTH-1:0]   field_t;
	typedef logic [2*FIELD_WIDTH-1:0] wide_t;

	// p = 2^256 - 2^32 - 977
	localparam field_t MODULUS =
		256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

	// Newton iteration for n^-1 mod 2^256, every pass doubles the correct low bits
	function automatic field_t neg_inverse(input field_t n);
		field_t x;
		x = n; // n*n = 1 mod 8 for odd n
		for (int i = 0; i < 8; i++) begin
			x = x * (field_t'(2) - n * x);
		end
		return field_t'(0) - x;
	endfunction

	localparam field_t MONT_NEG_INV = neg_inverse(MODULUS); // -p^-1 mod 2^256

	typedef enum logic [1:0] {
		OP_MONT_MUL = 2'b00,
		OP_MOD_ADD  = 2'b01,
		OP_MOD_SUB  = 2'b10,
		OP_MUL_LOW  = 2'b11
	} arith_op_t;

	typedef struct packed {
		arith_op_t op;
		field_t    a;
		field_t    b;
	} arith_req_t;

	typedef struct packed {
		field_t x;
		field_t y;
		logic   c_in;
	} add_req_t;

	typedef struct packed {
		logic [FIELD_WIDTH:0] x;
		logic [FIELD_WIDTH:0] y;
	} sub_req_t;

	typedef struct packed {
		field_t a;
		field_t b;
	} mul_req_t;

endpackage

// File: arith/word_mul.sv
`timescale 1ns/1ps

module word_mul
	import modarith_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  mul_req_t req,
	output wide_t    product,
	output logic     done
);

	mul_req_t                          req_q;
	wide_t                             acc;
	logic [$clog2(WORD_COUNT)-1:0]     word_idx;
	logic                              running;
	logic                              finishing;
	logic [WORD_WIDTH-1:0]             b_word;
	logic [FIELD_WIDTH+WORD_WIDTH-1:0] row;
	wide_t                             row_shifted;

	// ==================================================
	// Partial row for the current word of b
	// ==================================================
	assign b_word      = req_q.b[word_idx*WORD_WIDTH +: WORD_WIDTH];
	assign row         = {{WORD_WIDTH{1'b0}}, req_q.a} * b_word;
	assign row_shifted = wide_t'(row) << (word_idx * WORD_WIDTH);

	// Load, WORD_COUNT accumulate cycles, then one finish cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			running   <= 1'b0;
			finishing <= 1'b0;
			done      <= 1'b0;
			word_idx  <= '0;
		end else begin
			finishing <= 1'b0;
			done      <= finishing;
			if (start) begin
				running  <= 1'b1;
				word_idx <= '0;
			end else if (running) begin
				word_idx <= word_idx + 1'b1;
				if (word_idx == WORD_COUNT - 1) begin
					running   <= 1'b0;
					finishing <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			req_q <= req;
			acc   <= '0;
		end else if (running) begin
			acc <= acc + row_shifted;
		end
		if (finishing) begin
			product <= acc; // Held until the next product
		end
	end

endmodule

// File: arith/carry_select_add.sv
`timescale 1ns/1ps

module carry_select_add
	import modarith_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  add_req_t             req,
	output logic [FIELD_WIDTH:0] sum,
	output logic                 done
);

	logic [WORD_COUNT-1:0][WORD_WIDTH:0] part_c0; // Slice sums without carry in
	logic [WORD_COUNT-1:0][WORD_WIDTH:0] part_c1; // Slice sums with carry in
	logic                                c_in_q;
	logic                                stage2;
	logic [WORD_COUNT:0]                 carry;
	field_t                              sel_sum;

	// ==================================================
	// Stage 1
	// ==================================================
	always_ff @(posedge clk) begin
		if (start) begin
			for (int i = 0; i < WORD_COUNT; i++) begin
				part_c0[i] <= {1'b0, req.x[i*WORD_WIDTH +: WORD_WIDTH]}
					+ req.y[i*WORD_WIDTH +: WORD_WIDTH];
				part_c1[i] <= {1'b0, req.x[i*WORD_WIDTH +: WORD_WIDTH]}
					+ req.y[i*WORD_WIDTH +: WORD_WIDTH] + 1'b1;
			end
			c_in_q <= req.c_in;
		end
	end

	// Stage 2 ripples slice carries
	always_comb begin
		carry[0] = c_in_q;
		for (int i = 0; i < WORD_COUNT; i++) begin
			sel_sum[i*WORD_WIDTH +: WORD_WIDTH] = carry[i] ? part_c1[i][WORD_WIDTH-1:0]
				: part_c0[i][WORD_WIDTH-1:0];
			carry[i+1] = carry[i] ? part_c1[i][WORD_WIDTH] : part_c0[i][WORD_WIDTH];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			stage2 <= 1'b0;
			done   <= 1'b0;
		end else begin
			stage2 <= start;
			done   <= stage2;
		end
	end

	always_ff @(posedge clk) begin
		if (stage2) begin
			sum <= {carry[WORD_COUNT], sel_sum};
		end
	end

endmodule

// File: arith/borrow_sub.sv
`timescale 1ns/1ps

module borrow_sub
	import modarith_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  sub_req_t req,
	output field_t   diff,
	output logic     borrow,
	output logic     done
);

	logic [WORD_COUNT-1:0][WORD_WIDTH-1:0] diff_b0; // No borrow in
	logic [WORD_COUNT-1:0][WORD_WIDTH-1:0] diff_b1; // Borrow in
	logic [WORD_COUNT:0]                   brw_b0;  // Top entry is bit FIELD_WIDTH
	logic [WORD_COUNT:0]                   brw_b1;
	logic [WORD_COUNT+1:0]                 chain;
	field_t                                sel_diff;
	logic                                  stage2;

	// ==================================================
	// Stage 1
	// ==================================================
	always_ff @(posedge clk) begin
		if (start) begin
			for (int i = 0; i < WORD_COUNT; i++) begin
				{brw_b0[i], diff_b0[i]} <= {1'b0, req.x[i*WORD_WIDTH +: WORD_WIDTH]}
					- {1'b0, req.y[i*WORD_WIDTH +: WORD_WIDTH]};
				{brw_b1[i], diff_b1[i]} <= {1'b0, req.x[i*WORD_WIDTH +: WORD_WIDTH]}
					- {1'b0, req.y[i*WORD_WIDTH +: WORD_WIDTH]} - 1'b1;
			end
			brw_b0[WORD_COUNT] <= ~req.x[FIELD_WIDTH] & req.y[FIELD_WIDTH];
			brw_b1[WORD_COUNT] <= ~req.x[FIELD_WIDTH] | req.y[FIELD_WIDTH];
		end
	end

	always_comb begin
		chain[0] = 1'b0;
		for (int i = 0; i < WORD_COUNT; i++) begin
			sel_diff[i*WORD_WIDTH +: WORD_WIDTH] = chain[i] ? diff_b1[i] : diff_b0[i];
			chain[i+1] = chain[i] ? brw_b1[i] : brw_b0[i];
		end
		chain[WORD_COUNT+1] = chain[WORD_COUNT] ? brw_b1[WORD_COUNT] : brw_b0[WORD_COUNT];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			stage2 <= 1'b0;
			done   <= 1'b0;
		end else begin
			stage2 <= start;
			done   <= stage2;
		end
	end

	always_ff @(posedge clk) begin
		if (stage2) begin
			diff   <= sel_diff;
			borrow <= chain[WORD_COUNT+1]; // Borrow out of the full 257-bit difference
		end
	end

endmodule

// File: source/modarith_ctrl.sv
`timescale 1ns/1ps

module modarith_ctrl
	import modarith_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  arith_req_t           req,
	output mul_req_t             mul_req,
	output logic                 mul_start,
	input  wide_t                mul_product,
	input  logic                 mul_done,
	output add_req_t             add_req,
	output logic                 add_start,
	input  logic [FIELD_WIDTH:0] add_sum,
	input  logic                 add_done,
	output sub_req_t             sub_req,
	output logic                 sub_start,
	input  field_t               sub_diff,
	input  logic                 sub_borrow,
	input  logic                 sub_done,
	output field_t               result,
	output logic                 done,
	output logic                 busy
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_MUL_LOW,
		S_MM_T,      // T = A*B
		S_MM_M,      // m = T_low * -p^-1
		S_MM_MP,     // m*p
		S_MM_ADD_LO, // Only the carry is kept
		S_MM_ADD_HI, // t = T_high + mp_high + carry
		S_MM_SUB,
		S_MA_ADD,
		S_MA_SUB,
		S_MS_SUB,
		S_MS_ADD
	} state_t;

	state_t               state;
	arith_req_t           req_q;
	wide_t                t_prod;
	field_t               m;
	wide_t                mp;
	logic                 lo_carry;
	logic [FIELD_WIDTH:0] t_val; // Value awaiting correction against p

	// ==================================================
	// Unit requests, steady for the whole state
	// ==================================================
	always_comb begin
		mul_req.a = req_q.a;
		mul_req.b = req_q.b;
		case (state)
			S_MM_M: begin
				mul_req.a = t_prod[FIELD_WIDTH-1:0];
				mul_req.b = MONT_NEG_INV;
			end
			S_MM_MP: begin
				mul_req.a = m;
				mul_req.b = MODULUS;
			end
			default: ;
		endcase
	end

	always_comb begin
		add_req.x    = req_q.a;
		add_req.y    = req_q.b;
		add_req.c_in = 1'b0;
		case (state)
			S_MM_ADD_LO: begin
				add_req.x = t_prod[FIELD_WIDTH-1:0];
				add_req.y = mp[FIELD_WIDTH-1:0];
			end
			S_MM_ADD_HI: begin
				add_req.x    = t_prod[2*FIELD_WIDTH-1:FIELD_WIDTH];
				add_req.y    = mp[2*FIELD_WIDTH-1:FIELD_WIDTH];
				add_req.c_in = lo_carry;
			end
			S_MS_ADD: begin
				add_req.x = t_val[FIELD_WIDTH-1:0]; // Carry out dropped
				add_req.y = MODULUS;
			end
			default: ;
		endcase
	end

	always_comb begin
		if (state == S_MS_SUB) begin
			sub_req.x = {1'b0, req_q.a};
			sub_req.y = {1'b0, req_q.b};
		end else begin
			sub_req.x = t_val;
			sub_req.y = {1'b0, MODULUS};
		end
	end

	// ==================================================
	// Sequencing
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= S_IDLE;
			busy      <= 1'b0;
			done      <= 1'b0;
			result    <= '0;
			mul_start <= 1'b0;
			add_start <= 1'b0;
			sub_start <= 1'b0;
		end else begin
			done      <= 1'b0;
			mul_start <= 1'b0;
			add_start <= 1'b0;
			sub_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						req_q <= req;
						busy  <= 1'b1;
						case (req.op)
							OP_MUL_LOW: begin
								state     <= S_MUL_LOW;
								mul_start <= 1'b1;
							end
							OP_MONT_MUL: begin
								state     <= S_MM_T;
								mul_start <= 1'b1;
							end
							OP_MOD_ADD: begin
								state     <= S_MA_ADD;
								add_start <= 1'b1;
							end
							default: begin
								state     <= S_MS_SUB;
								sub_start <= 1'b1;
							end
						endcase
					end
				end
				S_MUL_LOW: begin
					if (mul_done) begin
						result <= mul_product[FIELD_WIDTH-1:0];
						done   <= 1'b1;
						busy   <= 1'b0;
						state  <= S_IDLE;
					end
				end
				S_MM_T: begin
					if (mul_done) begin
						t_prod    <= mul_product;
						state     <= S_MM_M;
						mul_start <= 1'b1;
					end
				end
				S_MM_M: begin
					if (mul_done) begin
						m         <= mul_product[FIELD_WIDTH-1:0];
						state     <= S_MM_MP;
						mul_start <= 1'b1;
					end
				end
				S_MM_MP: begin
					if (mul_done) begin
						mp        <= mul_product;
						state     <= S_MM_ADD_LO;
						add_start <= 1'b1;
					end
				end
				S_MM_ADD_LO: begin
					if (add_done) begin
						lo_carry  <= add_sum[FIELD_WIDTH];
						state     <= S_MM_ADD_HI;
						add_start <= 1'b1;
					end
				end
				S_MM_ADD_HI, S_MA_ADD: begin
					if (add_done) begin
						t_val     <= add_sum;
						state     <= (state == S_MA_ADD) ? S_MA_SUB : S_MM_SUB;
						sub_start <= 1'b1;
					end
				end
				S_MM_SUB, S_MA_SUB: begin
					if (sub_done) begin
						// Borrow means t < p
						result <= sub_borrow ? t_val[FIELD_WIDTH-1:0] : sub_diff;
						done   <= 1'b1;
						busy   <= 1'b0;
						state  <= S_IDLE;
					end
				end
				S_MS_SUB: begin
					if (sub_done) begin
						if (sub_borrow) begin
							t_val     <= {1'b0, sub_diff};
							state     <= S_MS_ADD;
							add_start <= 1'b1;
						end else begin
							result <= sub_diff;
							done   <= 1'b1;
							busy   <= 1'b0;
							state  <= S_IDLE;
						end
					end
				end
				S_MS_ADD: begin
					if (add_done) begin
						result <= add_sum[FIELD_WIDTH-1:0];
						done   <= 1'b1;
						busy   <= 1'b0;
						state  <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: source/modarith_top.sv
`timescale 1ns/1ps

module modarith_top
	import modarith_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  arith_req_t req,
	output field_t     result,
	output logic       done,
	output logic       busy
);

	mul_req_t             mul_req;
	logic                 mul_start;
	wide_t                mul_product;
	logic                 mul_done;
	add_req_t             add_req;
	logic                 add_start;
	logic [FIELD_WIDTH:0] add_sum;
	logic                 add_done;
	sub_req_t             sub_req;
	logic                 sub_start;
	field_t               sub_diff;
	logic                 sub_borrow;
	logic                 sub_done;

	modarith_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.req         (req),
		.mul_req     (mul_req),
		.mul_start   (mul_start),
		.mul_product (mul_product),
		.mul_done    (mul_done),
		.add_req     (add_req),
		.add_start   (add_start),
		.add_sum     (add_sum),
		.add_done    (add_done),
		.sub_req     (sub_req),
		.sub_start   (sub_start),
		.sub_diff    (sub_diff),
		.sub_borrow  (sub_borrow),
		.sub_done    (sub_done),
		.result      (result),
		.done        (done),
		.busy        (busy)
	);

	// ==================================================
	// Datapath units
	// ==================================================
	word_mul u_mul (
		.clk     (clk),
		.rst     (rst),
		.start   (mul_start),
		.req     (mul_req),
		.product (mul_product),
		.done    (mul_done)
	);

	carry_select_add u_add (
		.clk   (clk),
		.rst   (rst),
		.start (add_start),
		.req   (add_req),
		.sum   (add_sum),
		.done  (add_done)
	);

	borrow_sub u_sub (
		.clk    (clk),
		.rst    (rst),
		.start  (sub_start),
		.req    (sub_req),
		.diff   (sub_diff),
		.borrow (sub_borrow),
		.done   (sub_done)
	);

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (10) @(negedge clk);
		rst = 1'b0;
	end

endmodule

// File: tb/modarith_properties.sv
`timescale 1ns/1ps

module modarith_properties (
	input logic clk,
	input logic rst,
	input logic start,
	input logic done,
	input logic busy
);

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else $error("done stayed high for more than one cycle");

	a_busy_falls: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> done)
		else $error("busy fell without done");

	a_done_idle: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
		else $error("busy still high while done is high");

	// Only the end of a busy period may raise done
	a_done_ends_busy: assert property (@(posedge clk) disable iff (rst) done |-> $past(busy))
		else $error("done arrived without a request in flight");

	a_busy_needs_start: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> $past(start))
		else $error("busy rose without a start");

	// Outputs idle right after reset
	a_reset_idle: assert property (@(posedge clk) $past(rst) |-> (!done && !busy))
		else $error("done or busy high after reset");

endmodule

// File: tb/modarith_checker.sv
`timescale 1ns/1ps

module modarith_checker
	import modarith_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  arith_req_t req,
	input  field_t     result,
	input  logic       done,
	input  logic       busy,
	output int         pass_count,
	output int         fail_count,
	output int         extra_count
);

	arith_req_t held;    // Request that is in flight
	logic       pending;
	int         test_idx;

	// ==================================================
	// Expected values from the field rules
	// ==================================================
	task automatic check_result(input arith_req_t r, input field_t got, output logic ok);
		logic [2*FIELD_WIDTH-1:0] prod;
		logic [2*FIELD_WIDTH-1:0] shifted;
		logic [2*FIELD_WIDTH-1:0] p_wide;
		logic [FIELD_WIDTH:0]     sum;
		logic [FIELD_WIDTH:0]     p_ext;
		field_t                   expected;
		ok       = 1'b1;
		p_wide   = {{FIELD_WIDTH{1'b0}}, MODULUS};
		p_ext    = {1'b0, MODULUS};
		prod     = {{FIELD_WIDTH{1'b0}}, r.a} * {{FIELD_WIDTH{1'b0}}, r.b};
		expected = got;
		case (r.op)
			OP_MUL_LOW: expected = prod[FIELD_WIDTH-1:0];
			OP_MOD_ADD: begin
				sum = {1'b0, r.a} + {1'b0, r.b};
				if (sum >= p_ext)
					sum = sum - p_ext; // Equal to p reduces to zero
				expected = sum[FIELD_WIDTH-1:0];
			end
			OP_MOD_SUB: expected = (r.a >= r.b) ? r.a - r.b : r.a - r.b + MODULUS;
			default: ;
		endcase
		if ($isunknown(got)) begin
			$display("MISMATCH result: got %h, which has unknown bits", got);
			ok = 1'b0;
		end else if (r.op == OP_MONT_MUL) begin
			// result*2^256 must be congruent to A*B
			shifted = {got, {FIELD_WIDTH{1'b0}}} % p_wide;
			prod    = prod % p_wide;
			if (got >= MODULUS) begin
				$display("MISMATCH result: got %h, expected below %h", got, MODULUS);
				ok = 1'b0;
			end else if (shifted != prod) begin
				$display("MISMATCH result: got %h, result*2^256 mod p %h, A*B mod p %h",
					got, shifted[FIELD_WIDTH-1:0], prod[FIELD_WIDTH-1:0]);
				ok = 1'b0;
			end
		end else if (got !== expected) begin
			$display("MISMATCH result: got %h expected %h", got, expected);
			ok = 1'b0;
		end
	endtask

	always @(posedge clk) begin
		logic ok;
		if (rst) begin
			pending     = 1'b0;
			test_idx    = 0;
			pass_count  = 0;
			fail_count  = 0;
			extra_count = 0;
		end else begin
			if (done) begin
				if (!pending) begin
					extra_count++;
					$display("done pulse arrived with no request outstanding");
				end else begin
					check_result(held, result, ok);
					if (ok)
						pass_count++;
					else
						fail_count++;
					$display("test %0d %s %s", test_idx, held.op.name(), ok ? "ok" : "failed");
					test_idx++;
					pending = 1'b0;
				end
			end
			if (start && !busy) begin // A start while busy is dropped by the DUT
				held    = req;
				pending = 1'b1;
			end
		end
	end

endmodule

// File: tb/modarith_tb.sv
`timescale 1ns/1ps

module modarith_tb
	import modarith_pkg::*;
();

	typedef struct packed {
		arith_op_t op;
		field_t    a;
		field_t    b;
		logic      rnd; // Operands come from the LFSR
	} row_t;

	logic        clk;
	logic        rst;
	logic        start;
	arith_req_t  req;
	field_t      result;
	logic        done;
	logic        busy;
	int          pass_count;
	int          fail_count;
	int          extra_count;
	row_t        rows[$];
	logic [31:0] lfsr;
	logic        timed_out;

	clk_gen clk_gen0 (
		.clk (clk),
		.rst (rst)
	);

	modarith_top dut0 (
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.req    (req),
		.result (result),
		.done   (done),
		.busy   (busy)
	);

	modarith_checker checker0 (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.req         (req),
		.result      (result),
		.done        (done),
		.busy        (busy),
		.pass_count  (pass_count),
		.fail_count  (fail_count),
		.extra_count (extra_count)
	);

	bind modarith_top modarith_properties props0 (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.done  (done),
		.busy  (busy)
	);

	// ==================================================
	// Random operands
	// ==================================================
	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_field(output field_t v);
		v = '0;
		for (int i = 0; i < FIELD_WIDTH; i++) begin
			lfsr = lfsr_next(lfsr); // One step per bit
			v    = {v[FIELD_WIDTH-2:0], lfsr[0]};
		end
		v = v % MODULUS;
	endtask

	task automatic add_row(input arith_op_t op, input field_t a, input field_t b, input logic rnd);
		rows.push_back(row_t'{op: op, a: a, b: b, rnd: rnd});
	endtask

	task automatic build_table();
		field_t pm1;
		pm1 = MODULUS - 1;
		add_row(OP_MUL_LOW, '0, pm1, 1'b0);
		add_row(OP_MUL_LOW, pm1, pm1, 1'b0);
		add_row(OP_MUL_LOW, 256'h1234_5678_9abc_def0, 256'hffff_ffff_0000_0001_ffff_ffff, 1'b0);
		add_row(OP_MUL_LOW, '0, '0, 1'b1);
		add_row(OP_MOD_ADD, 256'd5, 256'd7, 1'b0);  // Below p
		add_row(OP_MOD_ADD, pm1, 256'd1, 1'b0);     // Exactly p
		add_row(OP_MOD_ADD, MODULUS - 10, 256'd10, 1'b0);
		add_row(OP_MOD_ADD, pm1, pm1, 1'b0);        // Above p
		add_row(OP_MOD_ADD, MODULUS - 5, 256'd100, 1'b0);
		add_row(OP_MOD_ADD, '0, '0, 1'b1);
		add_row(OP_MOD_SUB, 256'd9, 256'd4, 1'b0);
		add_row(OP_MOD_SUB, 256'd4, 256'd9, 1'b0);
		add_row(OP_MOD_SUB, 256'habc, 256'habc, 1'b0);
		add_row(OP_MOD_SUB, '0, pm1, 1'b0);
		add_row(OP_MOD_SUB, '0, '0, 1'b1);
		add_row(OP_MONT_MUL, '0, 256'd5, 1'b0);
		add_row(OP_MONT_MUL, 256'd1, 256'd1, 1'b0);
		add_row(OP_MONT_MUL, pm1, pm1, 1'b0);
		add_row(OP_MONT_MUL, 256'd1 << 255, 256'd3, 1'b0);
		for (int i = 0; i < 20; i++) begin
			add_row(OP_MONT_MUL, '0, '0, 1'b1);
		end
	endtask

	// One request, plus a start while busy that must be dropped
	task automatic run_row(input row_t r, output logic late);
		int cycles;
		@(negedge clk);
		req.op = r.op;
		req.a  = r.a;
		req.b  = r.b;
		start  = 1'b1;
		@(negedge clk);
		start = 1'b0;
		@(negedge clk);
		req.op = OP_MUL_LOW;
		req.a  = ~r.a;
		start  = 1'b1;
		@(negedge clk);
		start  = 1'b0;
		cycles = 0;
		while (!done && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		late = !done;
		@(negedge clk);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		int   cycles;
		row_t r;
		start     = 1'b0;
		req       = '0;
		lfsr      = 32'd87;
		timed_out = 1'b0;
		build_table();
		@(negedge clk);
		cycles = 0;
		while (rst && cycles < 50) begin
			@(negedge clk);
			cycles++;
		end
		if (rst) begin
			$display("reset was never released");
			timed_out = 1'b1;
		end
		for (int i = 0; i < rows.size() && !timed_out; i++) begin
			r = rows[i];
			if (r.rnd) begin
				draw_field(r.a);
				draw_field(r.b);
			end
			run_row(r, timed_out);
			if (timed_out)
				$display("timeout: no done within 200 cycles on row %0d", i);
		end
		repeat (4) @(negedge clk); // Catch stray done pulses
		$display("tests passed %0d, failed %0d, extra done pulses %0d",
			pass_count, fail_count, extra_count);
		if (!timed_out && fail_count == 0 && extra_count == 0 && pass_count == rows.size())
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: modarith_top.f
common/modarith_pkg.sv
arith/word_mul.sv
arith/carry_select_add.sv
arith/borrow_sub.sv
source/modarith_ctrl.sv
source/modarith_top.sv
tb/clk_gen.sv
tb/modarith_properties.sv
tb/modarith_checker.sv
tb/modarith_tb.sv
